// ==== dv/tb_adc_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture;

  import adc_cfg_pkg::*;
  import adc_frame_pkg::*;

  // ----------------------------------------------------------------------
  // run length
  // ----------------------------------------------------------------------
  localparam int RESET_CYCLES = 3;
  localparam int WR_DELAY     = EXTRA_REG ? 2 : 1;  // slot 3 edge to fifo write edge
  localparam int TEST_FRAMES  = 4 + 20 + 4 + 3 + (FIFO_DEPTH + 2) + 5;
  localparam int DRAIN_CYCLES = 4 * FIFO_DEPTH;     // worst drain of a full fifo
  localparam int MAX_CYCLES   = SAMPLES_PER_FRAME * TEST_FRAMES + 6 * DRAIN_CYCLES
                                + 2 * RESET_CYCLES + 200;

  logic       adc_clk = 1'b0;
  logic       dcm_reset;
  lane_word_t lane;
  logic       sync;
  logic       overrange;
  logic       out_ready;
  adc_frame_t out_frame;
  logic       out_valid;
  logic       overflow;

  adc_frame_t        exp_q[$];    // frames the fifo should hold in arrival order
  adc_frame_t        m_word;      // model frame being gathered
  adc_frame_t        pend_word;   // built but not yet written
  adc_frame_t        stall_word;  // output seen in a stalled cycle
  logic [SLOT_W-1:0] m_slot;
  logic [SLOT_W-1:0] drv_slot;    // slot that the next driven sample lands in
  int                pend_cnt;
  int                resolved;
  int                done_cnt = 0;  // frames popped or dropped since reset
  int                drv_frames;
  int                cycles = 0;
  int                seed = 32'h4ba0;
  logic              exp_ovf;
  logic              stall_prev;
  logic              full_now;
  string             test_name = "reset";

  always #2 adc_clk = ~adc_clk;

  adc_capture_top dut_i (.*);

  task automatic abort_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_frame(string name, adc_frame_t exp, adc_frame_t act);
    if (exp !== act) begin
      $display("mismatch %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("mismatch %s expected %b actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // ----------------------------------------------------------------------
  // reference model sees the same pre-edge values as the dut
  // ----------------------------------------------------------------------
  always @(posedge adc_clk) begin
    if (dcm_reset) begin
      exp_q.delete();
      m_slot     = '0;
      pend_cnt   = 0;
      exp_ovf    = 1'b0;
      stall_prev = 1'b0;
      done_cnt  <= 0;
    end else begin
      resolved = 0;
      if (stall_prev) begin
        check_bit({test_name, " valid held"}, 1'b1, out_valid);
        check_frame({test_name, " word held"}, stall_word, out_frame);
      end
      check_bit({test_name, " overflow"}, exp_ovf, overflow);
      full_now = (exp_q.size() == FIFO_DEPTH);  // occupancy before this edge
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("output transfer in %s while no frame was expected", test_name);
          abort_run();
        end else begin
          check_frame(test_name, exp_q[0], out_frame);
          void'(exp_q.pop_front());
          resolved++;
        end
      end
      if (pend_cnt != 0) begin
        pend_cnt--;
        if (pend_cnt == 0 && full_now) begin
          exp_ovf = 1'b1;  // frame dropped
          resolved++;
        end else if (pend_cnt == 0) begin
          exp_q.push_back(pend_word);
        end
      end
      // status restarts at slot 0
      if (m_slot == '0) begin
        m_word.status = '0;
      end
      m_word.status.sync[m_slot] = sync;
      m_word.status.outofrange[m_slot >= SLOT_W'(SAMPLES_PER_FRAME / 2)] |= overrange;
      m_word.samples.di_d[m_slot] = lane.di_d;
      m_word.samples.di[m_slot]   = lane.di;
      m_word.samples.dq_d[m_slot] = lane.dq_d;
      m_word.samples.dq[m_slot]   = lane.dq;
      if (m_slot == SLOT_W'(SAMPLES_PER_FRAME - 1)) begin
        pend_word = m_word;
        pend_cnt  = WR_DELAY;
      end
      m_slot     = m_slot + 1'b1;
      stall_prev = out_valid && !out_ready;
      stall_word = out_frame;
      done_cnt  <= done_cnt + resolved;
    end
  end

  always @(posedge adc_clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      abort_run();
    end
  end

  // ----------------------------------------------------------------------
  // drive helpers called just after a rising edge
  // ----------------------------------------------------------------------
  function automatic lane_word_t slot_pattern(int f, logic [SLOT_W-1:0] s);
    lane_word_t w;
    w.di_d = sample_t'(192 + 16 * (f % 4) + int'(s));  // channel in bits 7:6
    w.di   = sample_t'(128 + 16 * (f % 4) + int'(s));
    w.dq_d = sample_t'(64 + 16 * (f % 4) + int'(s));
    w.dq   = sample_t'(16 * (f % 4) + int'(s));
    return w;
  endfunction

  task automatic drive_slot(lane_word_t l, logic s, logic o);
    lane      <= l;
    sync      <= s;
    overrange <= o;
    if (drv_slot == SLOT_W'(SAMPLES_PER_FRAME - 1)) begin
      drv_frames++;
    end
    drv_slot = drv_slot + 1'b1;
    @(posedge adc_clk);
  endtask

  // idle input until every frame driven so far is resolved
  task automatic drain();
    int target;
    target = drv_frames;
    while (done_cnt < target || drv_slot != '0) begin
      drive_slot('0, 1'b0, 1'b0);
    end
  endtask

  task automatic reset_dut();
    dcm_reset <= 1'b1;
    @(posedge adc_clk);
    @(negedge adc_clk);
    check_bit({test_name, " out_valid after reset"}, 1'b0, out_valid);
    check_bit({test_name, " overflow after reset"}, 1'b0, overflow);
    repeat (RESET_CYCLES - 1) @(posedge adc_clk);
    dcm_reset <= 1'b0;
    drv_slot   = '0;  // next sample is slot 0
    drv_frames = 0;
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic count_slots();
    test_name = "count_slots";
    out_ready <= 1'b1;
    for (int f = 0; f < 4; f++) begin
      repeat (SAMPLES_PER_FRAME) drive_slot(slot_pattern(f, drv_slot), 1'b0, 1'b0);
    end
    drain();
  endtask

  task automatic random_data();
    test_name = "random_data";
    repeat (20 * SAMPLES_PER_FRAME) drive_slot(lane_word_t'($random(seed)), 1'b0, 1'b0);
    drain();
    check_bit("random_data overflow low", 1'b0, overflow);
  endtask

  task automatic status_bits();
    logic [SAMPLES_PER_FRAME-1:0] mask;
    logic [SLOT_W-1:0]            lo;
    logic [SLOT_W-1:0]            hi;
    test_name = "status_bits";
    for (int f = 0; f < 4; f++) begin
      mask = SAMPLES_PER_FRAME'(5 * f + 1);  // 0001 0110 1011 0000
      lo   = SLOT_W'(f % 2);                  // one over-range slot per half
      hi   = SLOT_W'(2 + (f / 2) % 2);
      repeat (SAMPLES_PER_FRAME) begin
        drive_slot(lane_word_t'($random(seed)), mask[drv_slot],
                   drv_slot == lo || drv_slot == hi);
      end
    end
    drain();
  endtask

  task automatic stall_release();
    test_name = "stall_release";
    out_ready <= 1'b0;  // three frames pile up
    repeat (3 * SAMPLES_PER_FRAME) drive_slot(lane_word_t'($random(seed)), 1'b0, 1'b0);
    out_ready <= 1'b1;
    drain();
  endtask

  task automatic overflow_drop();
    test_name = "overflow_drop";
    out_ready <= 1'b0;
    repeat ((FIFO_DEPTH + 2) * SAMPLES_PER_FRAME) begin
      drive_slot(lane_word_t'($random(seed)), 1'b0, 1'b0);
    end
    check_bit("overflow_drop raised", 1'b1, overflow);
    out_ready <= 1'b1;
    drain();  // only the kept frames come out
  endtask

  task automatic reset_mid_stream();
    test_name = "reset_mid_stream";
    out_ready <= 1'b0;  // a frame waits at the output when reset hits
    repeat (10) drive_slot(lane_word_t'($random(seed)), 1'b1, 1'b1);
    reset_dut();
    out_ready <= 1'b1;
    for (int f = 0; f < 2; f++) begin
      repeat (SAMPLES_PER_FRAME) drive_slot(slot_pattern(f, drv_slot), 1'b0, 1'b0);
    end
    drain();
  endtask

  initial begin
    dcm_reset <= 1'b1;
    lane      <= '0;
    sync      <= 1'b0;
    overrange <= 1'b0;
    out_ready <= 1'b1;
    reset_dut();
    count_slots();
    random_data();
    status_bits();
    stall_release();
    overflow_drop();
    reset_mid_stream();
    check_bit("final overflow", 1'b0, overflow);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/adc_cfg_pkg.sv
hdl/adc_frame_pkg.sv
hdl/sample_deserializer.sv
hdl/frame_builder.sv
hdl/frame_fifo.sv
hdl/adc_capture_top.sv
dv/tb_adc_capture.sv

// ==== hdl/adc_capture_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_capture_top (
  input  logic                      adc_clk,
  input  logic                      dcm_reset,
  input  adc_frame_pkg::lane_word_t lane,
  input  logic                      sync,
  input  logic                      overrange,
  input  logic                      out_ready,
  output adc_frame_pkg::adc_frame_t out_frame,
  output logic                      out_valid,
  output logic                      overflow
);

  import adc_cfg_pkg::*;
  import adc_frame_pkg::*;

  // ----------------------------------------------------------------------
  // stage wiring
  // ----------------------------------------------------------------------
  logic [SLOT_W-1:0] slot;        // current sample slot
  sample_frame_t     frame;       // gathered samples
  logic              frame_done;
  adc_frame_t        wr_frame;    // samples plus status
  logic              wr_valid;

  sample_deserializer u_deser (
    .adc_clk    (adc_clk),
    .dcm_reset  (dcm_reset),
    .lane       (lane),
    .slot       (slot),
    .frame      (frame),
    .frame_done (frame_done)
  );

  frame_builder u_build (
    .adc_clk    (adc_clk),
    .dcm_reset  (dcm_reset),
    .sync       (sync),
    .overrange  (overrange),
    .slot       (slot),
    .frame      (frame),
    .frame_done (frame_done),
    .wr_frame   (wr_frame),
    .wr_valid   (wr_valid)
  );

  // no back-pressure toward the builder
  frame_fifo u_fifo (
    .adc_clk   (adc_clk),
    .dcm_reset (dcm_reset),
    .wr_frame  (wr_frame),
    .wr_valid  (wr_valid),
    .out_ready (out_ready),
    .out_frame (out_frame),
    .out_valid (out_valid),
    .overflow  (overflow)
  );

endmodule

`default_nettype wire

// ==== hdl/adc_cfg_pkg.sv ====
`default_nettype none

package adc_cfg_pkg;

  // ----------------------------------------------------------------------
  // sample geometry
  // ----------------------------------------------------------------------
  localparam int SAMPLE_W          = 8;  // bits per adc sample
  localparam int NUM_CH            = 4;  // di_d, di, dq_d, dq
  localparam int SAMPLES_PER_FRAME = 4;  // samples per channel per frame
  localparam int SLOT_W            = 2;  // index of the sample within a frame

  // ----------------------------------------------------------------------
  // frame buffer
  // ----------------------------------------------------------------------
  localparam int FIFO_DEPTH = 8;                    // frames held, power of two
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);   // pointer width
  localparam int FIFO_CNT_W = FIFO_AW + 1;          // occupancy needs 0..DEPTH

  // register stage between frame assembly and the fifo
  // helps timing on the 134 bit wide write path
  localparam bit EXTRA_REG = 1'b1;

endpackage

`default_nettype wire

// ==== hdl/adc_frame_pkg.sv ====
`default_nettype none

package adc_frame_pkg;

  import adc_cfg_pkg::*;

  // ----------------------------------------------------------------------
  // per cycle input
  // ----------------------------------------------------------------------
  typedef logic [SAMPLE_W-1:0] sample_t;

  // one sample per channel, di_d in the top byte
  typedef struct packed {
    sample_t di_d;
    sample_t di;
    sample_t dq_d;
    sample_t dq;
  } lane_word_t;

  // ----------------------------------------------------------------------
  // gathered frame
  // ----------------------------------------------------------------------
  // slot 0 sits in the low byte
  typedef logic [SAMPLES_PER_FRAME-1:0][SAMPLE_W-1:0] channel_frame_t;

  typedef struct packed {
    channel_frame_t di_d;
    channel_frame_t di;
    channel_frame_t dq_d;
    channel_frame_t dq;
  } sample_frame_t;

  typedef struct packed {
    logic [SAMPLES_PER_FRAME-1:0] sync;        // bit k = sync seen in slot k
    logic [1:0]                   outofrange;  // bit 0 slots 0-1, bit 1 slots 2-3
  } frame_status_t;

  // fifo word, status on top
  typedef struct packed {
    frame_status_t status;
    sample_frame_t samples;
  } adc_frame_t;

endpackage

`default_nettype wire

// ==== hdl/frame_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_builder (
  input  logic                           adc_clk,
  input  logic                           dcm_reset,
  input  logic                           sync,
  input  logic                           overrange,
  input  logic [adc_cfg_pkg::SLOT_W-1:0] slot,
  input  adc_frame_pkg::sample_frame_t   frame,
  input  logic                           frame_done,
  output adc_frame_pkg::adc_frame_t      wr_frame,
  output logic                           wr_valid
);

  import adc_cfg_pkg::*;
  import adc_frame_pkg::*;

  frame_status_t status_q;     // status of the frame being gathered
  adc_frame_t    frame_word;   // assembled word ahead of the fifo
  logic          second_half;  // slots 2-3

  assign second_half = slot[SLOT_W-1];

  // ----------------------------------------------------------------------
  // sync and over-range capture
  // ----------------------------------------------------------------------
  // one sync bit per slot, over-range folded per half frame
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      status_q <= '0;
    end else begin
      status_q.sync[slot] <= sync;
      if (slot == '0) begin
        // new frame starts
        status_q.sync[SAMPLES_PER_FRAME-1:1] <= '0;
        status_q.outofrange                  <= {1'b0, overrange};
      end else if (slot == SLOT_W'(SAMPLES_PER_FRAME / 2)) begin
        status_q.outofrange[1] <= overrange;  // second half restarts
      end else begin
        status_q.outofrange[second_half] <= status_q.outofrange[second_half] | overrange;
      end
    end
  end

  // status_q is complete while frame_done is high
  // and is only overwritten at the following slot 0 edge
  assign frame_word.status  = status_q;
  assign frame_word.samples = frame;

  // ----------------------------------------------------------------------
  // optional register stage
  // ----------------------------------------------------------------------
  generate
    if (EXTRA_REG) begin : g_extra_reg
      always_ff @(posedge adc_clk) begin
        if (dcm_reset) begin
          wr_valid <= 1'b0;
        end else begin
          wr_valid <= frame_done;
        end
      end

      always_ff @(posedge adc_clk) begin
        if (frame_done) begin
          wr_frame <= frame_word;
        end
      end

      a_wr_after_done: assert property (@(posedge adc_clk) disable iff (dcm_reset)
        wr_valid |-> $past(frame_done));
    end else begin : g_bypass
      assign wr_frame = frame_word;  // straight into the fifo
      assign wr_valid = frame_done;
    end
  endgenerate

  // deserializer strobe lands in the slot 0 cycle of the next frame
  a_done_at_slot0: assert property (@(posedge adc_clk) disable iff (dcm_reset)
    frame_done |-> slot == '0);

endmodule

`default_nettype wire

// ==== hdl/frame_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_fifo (
  input  logic                      adc_clk,
  input  logic                      dcm_reset,
  input  adc_frame_pkg::adc_frame_t wr_frame,
  input  logic                      wr_valid,
  input  logic                      out_ready,
  output adc_frame_pkg::adc_frame_t out_frame,
  output logic                      out_valid,
  output logic                      overflow
);

  import adc_cfg_pkg::*;
  import adc_frame_pkg::*;

  adc_frame_t            mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0]    wr_ptr;
  logic [FIFO_AW-1:0]    rd_ptr;
  logic [FIFO_CNT_W-1:0] count;    // memory entries plus the output word
  logic                  full;
  logic                  wr_en;
  logic                  pop;
  logic                  mem_has;  // something waiting behind out_frame
  logic                  load;     // move oldest entry to the output

  assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign wr_en   = wr_valid && !full;  // frame dropped when full
  assign pop     = out_valid && out_ready;
  assign mem_has = (count > FIFO_CNT_W'(out_valid));
  assign load    = mem_has && (!out_valid || pop);

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_frame;
    end
    if (load) begin
      out_frame <= mem[rd_ptr];  // held until popped
    end
  end

  // ----------------------------------------------------------------------
  // pointers, occupancy and flags
  // ----------------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
      end
      if (load) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + FIFO_CNT_W'(wr_en) - FIFO_CNT_W'(pop);

      if (load) begin
        out_valid <= 1'b1;
      end else if (pop) begin
        out_valid <= 1'b0;
      end

      // sticky until reset
      if (wr_valid && full) begin
        overflow <= 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge adc_clk) disable iff (dcm_reset)
    count <= FIFO_CNT_W'(FIFO_DEPTH));

  // stalled output holds word and valid
  a_hold_stall: assert property (@(posedge adc_clk) disable iff (dcm_reset)
    out_valid && !out_ready |=> out_valid && $stable(out_frame));

endmodule

`default_nettype wire

// ==== hdl/sample_deserializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sample_deserializer (
  input  logic                           adc_clk,
  input  logic                           dcm_reset,
  input  adc_frame_pkg::lane_word_t      lane,
  output logic [adc_cfg_pkg::SLOT_W-1:0] slot,
  output adc_frame_pkg::sample_frame_t   frame,
  output logic                           frame_done
);

  import adc_cfg_pkg::*;
  import adc_frame_pkg::*;

  sample_t        [NUM_CH-1:0] lane_s;    // lane seen as a channel array
  channel_frame_t [NUM_CH-1:0] gather_q;  // partial frame per channel
  channel_frame_t [NUM_CH-1:0] gather_d;
  logic                        last_slot;

  // index NUM_CH-1 is di_d in both the lane word and the frame
  assign lane_s    = lane;
  assign last_slot = (slot == SLOT_W'(SAMPLES_PER_FRAME - 1));

  // ----------------------------------------------------------------------
  // gathering
  // ----------------------------------------------------------------------
  // drop this cycle's sample into position slot of every channel
  always_comb begin
    gather_d = gather_q;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      gather_d[ch][slot] = lane_s[ch];
    end
  end

  always_ff @(posedge adc_clk) begin
    gather_q <= gather_d;
    if (last_slot) begin
      frame <= sample_frame_t'(gather_d);  // includes the slot 3 sample
    end
  end

  // ----------------------------------------------------------------------
  // slot counter and frame strobe
  // ----------------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (dcm_reset) begin
      slot       <= '0;  // first cycle after reset is slot 0
      frame_done <= 1'b0;
    end else begin
      if (last_slot) begin
        slot <= '0;
      end else begin
        slot <= slot + 1'b1;
      end
      frame_done <= last_slot;  // one cycle after slot 3
    end
  end

  // frames are SAMPLES_PER_FRAME apart so the strobe never doubles up
  a_done_single: assert property (@(posedge adc_clk) disable iff (dcm_reset)
    frame_done |=> !frame_done);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the adc capture testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
  --top-module tb_adc_capture -f files.f -o tb_adc_capture

# the log decides pass or fail
./obj_dir/tb_adc_capture > sim.log 2>&1 || true
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
